// File: Makefile
SIM       = verilator
TOP       = axis_maxpool_tb
FILELIST  = build.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -Wno-fatal -j 0
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/axis_maxpool_chk.sv
`timescale 1ns/10ps
`include "pool_defaults.svh"

module axis_maxpool_chk #(
  parameter int UNITS        = `UNITS,
  parameter int GROUPS       = `GROUPS,
  parameter int WORD_WIDTH   = `WORD_WIDTH,
  parameter int KERNEL_H_MAX = `KERNEL_H_MAX
) (
  input logic                                                  aclk,
  input logic                                                  reset,
  input logic                                                  m_axis_tvalid,
  input logic                                                  m_axis_tready,
  input logic [2*GROUPS*(UNITS+KERNEL_H_MAX-1)*WORD_WIDTH-1:0] m_axis_tdata,
  input logic [2*GROUPS*(UNITS+KERNEL_H_MAX-1)-1:0]            m_axis_tkeep,
  input logic                                                  m_axis_tlast
);

  localparam int UNITS_EDGES = UNITS + KERNEL_H_MAX - 1;
  localparam int PAD         = KERNEL_H_MAX / 2;
  localparam int OUT_W       = 2 * GROUPS * UNITS_EDGES * WORD_WIDTH;

  int unsigned assert_failures = 0;

  // ones over every edge word of every row and group
  function automatic logic [OUT_W-1:0] pad_mask();
    logic [OUT_W-1:0] mask;
    mask = '0;
    for (int w = 0; w < 2 * GROUPS * UNITS_EDGES; w++) begin
      if ((w % UNITS_EDGES) < PAD || (w % UNITS_EDGES) >= PAD + UNITS) begin
        mask[w*WORD_WIDTH +: WORD_WIDTH] = '1;
      end
    end
    return mask;
  endfunction

  localparam logic [OUT_W-1:0] PAD_MASK = pad_mask();

  a_idle_after_reset: assert property (@(posedge aclk) reset |=> !m_axis_tvalid)
    else begin
      assert_failures++;
      $error("m_axis_tvalid high in the cycle after reset");
    end

  // stalled beat must not change
  a_hold_on_stall: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tkeep) && $stable(m_axis_tlast))
    else begin
      assert_failures++;
      $error("output beat dropped or changed while stalled");
    end

  a_zero_edges: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid |-> (m_axis_tdata & PAD_MASK) == '0)
    else begin
      assert_failures++;
      $error("nonzero padding word on the output");
    end

endmodule

bind axis_maxpool_engine axis_maxpool_chk #(
  .UNITS       (UNITS),
  .GROUPS      (GROUPS),
  .WORD_WIDTH  (WORD_WIDTH),
  .KERNEL_H_MAX(KERNEL_H_MAX)
) u_chk (
  .aclk         (aclk),
  .reset        (reset),
  .m_axis_tvalid(m_axis_tvalid),
  .m_axis_tready(m_axis_tready),
  .m_axis_tdata (m_axis_tdata),
  .m_axis_tkeep (m_axis_tkeep),
  .m_axis_tlast (m_axis_tlast)
);

// File: bench/axis_maxpool_tb.sv
`timescale 1ns/10ps
`include "pool_defaults.svh"

module axis_maxpool_tb
  import pool_user_pkg::*;
  import pool_debug_pkg::*;
();

  localparam int UNITS          = `UNITS;
  localparam int GROUPS         = `GROUPS;
  localparam int WORD_WIDTH     = `WORD_WIDTH;
  localparam int KERNEL_H_MAX   = `KERNEL_H_MAX;
  localparam int UNITS_EDGES    = UNITS + KERNEL_H_MAX - 1;
  localparam int PAD            = KERNEL_H_MAX / 2;
  localparam int IN_W           = 2 * GROUPS * UNITS * WORD_WIDTH;
  localparam int OUT_WORDS      = 2 * GROUPS * UNITS_EDGES;
  localparam int OUT_W          = OUT_WORDS * WORD_WIDTH;
  localparam int BP_BEATS       = 150;
  localparam int TIMEOUT_CYCLES = 4000;  // 196 beats at 20 cycles each rounded up
  localparam logic [WORD_WIDTH-1:0] MOST_POS  = {1'b0, {(WORD_WIDTH-1){1'b1}}};
  localparam logic [WORD_WIDTH-1:0] MOST_NEG  = {1'b1, {(WORD_WIDTH-1){1'b0}}};
  localparam logic [WORD_WIDTH-1:0] MINUS_TWO = {{(WORD_WIDTH-1){1'b1}}, 1'b0};

  typedef struct packed {
    logic [OUT_W-1:0]     data;
    logic [OUT_WORDS-1:0] keep;
    logic                 last;
    logic [31:0]          accept_cycle;  // edge on which the input beat was taken
  } expected_t;

  logic                 aclk;
  logic                 reset;
  pool_debug_t          debug_config;
  logic                 s_axis_tvalid;
  logic                 s_axis_tready;
  logic [IN_W-1:0]      s_axis_tdata;
  pool_user_t           s_axis_tuser;
  logic                 m_axis_tvalid;
  logic                 m_axis_tready = 1'b1;
  logic [OUT_W-1:0]     m_axis_tdata;
  logic [OUT_WORDS-1:0] m_axis_tkeep;
  logic                 m_axis_tlast;

  expected_t   expected_q[$];
  logic [31:0] cycle_count = '0;
  logic [31:0] first_accept;
  logic [31:0] last_accept;
  int          error_count = 0;
  int          check_count = 0;
  int          tests_run = 0;
  int          test_errors = 0;
  int unsigned total_accepted = 0;
  logic        random_ready = 1'b0;  // consumer stalls at random
  logic        check_latency = 1'b0;
  string       test_name = "reset";
  pool_user_t  last_user;

  axis_maxpool_engine #(
    .UNITS       (UNITS),
    .GROUPS      (GROUPS),
    .WORD_WIDTH  (WORD_WIDTH),
    .KERNEL_H_MAX(KERNEL_H_MAX)
  ) u_dut (
    .aclk         (aclk),
    .reset        (reset),
    .debug_config (debug_config),
    .s_axis_tvalid(s_axis_tvalid),
    .s_axis_tready(s_axis_tready),
    .s_axis_tdata (s_axis_tdata),
    .s_axis_tuser (s_axis_tuser),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .m_axis_tdata (m_axis_tdata),
    .m_axis_tkeep (m_axis_tkeep),
    .m_axis_tlast (m_axis_tlast)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles in test %s, %0d beats never came out",
             TIMEOUT_CYCLES, test_name, expected_q.size());
    $display("Simulation failed");
    $finish;
  end

  function automatic pool_user_t make_user(input logic not_max, input logic k3, input logic last);
    pool_user_t user;
    user.is_not_max = not_max;
    user.kernel_h_1 = k3;
    user.last       = last;
    return user;
  endfunction

  function automatic logic [IN_W-1:0] random_beat(input logic negative);
    logic [IN_W-1:0] d;
    logic [31:0]     r;
    for (int i = 0; i < 2 * GROUPS * UNITS; i++) begin
      r = $urandom();
      d[i*WORD_WIDTH +: WORD_WIDTH] = r[WORD_WIDTH-1:0];
      if (negative) begin
        d[(i+1)*WORD_WIDTH-1] = 1'b1;
      end
    end
    return d;
  endfunction

  // a big word at the right edge of group 0 must not leak into group 1
  function automatic logic [IN_W-1:0] edge_beat();
    logic [IN_W-1:0] d;
    for (int i = 0; i < 2 * GROUPS * UNITS; i++) begin
      d[i*WORD_WIDTH +: WORD_WIDTH] = (i < GROUPS * UNITS) ? MOST_NEG : MINUS_TWO;
    end
    d[(GROUPS*UNITS + UNITS - 1)*WORD_WIDTH +: WORD_WIDTH] = MOST_POS;
    if (GROUPS > 1) begin
      d[(GROUPS*UNITS + UNITS)*WORD_WIDTH +: WORD_WIDTH] = MOST_NEG;
    end
    return d;
  endfunction

  // expected output beat from the pooling, keep and padding rules
  function automatic expected_t model_beat(input logic [IN_W-1:0] din, input pool_user_t user);
    expected_t                    beat;
    logic signed [WORD_WIDTH-1:0] vmax[UNITS];
    logic signed [WORD_WIDTH-1:0] w0;
    logic signed [WORD_WIDTH-1:0] w1;
    logic signed [WORD_WIDTH-1:0] best;
    int                           lo;
    int                           hi;
    beat      = '0;
    beat.last = user.last;
    for (int w = 0; w < OUT_WORDS; w++) begin
      beat.keep[w] = user.is_not_max || (w < GROUPS * UNITS_EDGES);  // row 0 always kept
    end
    if (user.is_not_max) begin
      for (int i = 0; i < 2 * GROUPS * UNITS; i++) begin
        beat.data[((i / UNITS) * UNITS_EDGES + PAD + i % UNITS) * WORD_WIDTH +: WORD_WIDTH] =
          din[i*WORD_WIDTH +: WORD_WIDTH];
      end
    end else begin
      for (int g = 0; g < GROUPS; g++) begin
        for (int u = 0; u < UNITS; u++) begin
          w0      = din[(g * UNITS + u) * WORD_WIDTH +: WORD_WIDTH];
          w1      = din[((GROUPS + g) * UNITS + u) * WORD_WIDTH +: WORD_WIDTH];
          vmax[u] = (w0 > w1) ? w0 : w1;
        end
        for (int u = 0; u < UNITS; u++) begin
          lo   = (user.kernel_h_1 && u > 0) ? u - 1 : u;  // window clipped at group edges
          hi   = (user.kernel_h_1 && u < UNITS - 1) ? u + 1 : u;
          best = vmax[lo];
          for (int k = lo + 1; k <= hi; k++) begin
            if (vmax[k] > best) begin
              best = vmax[k];
            end
          end
          beat.data[(g * UNITS_EDGES + PAD + u) * WORD_WIDTH +: WORD_WIDTH] = best;
        end
      end
    end
    return beat;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  // starts on a falling edge and returns on the one after the transfer
  task automatic send_beat(input logic [IN_W-1:0] data, input pool_user_t user);
    expected_t beat;
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = data;
    s_axis_tuser  = user;
    while (s_axis_tready !== 1'b1) begin
      @(negedge aclk);
    end
    beat              = model_beat(data, user);
    beat.accept_cycle = cycle_count + 1;  // taken on the coming rising edge
    expected_q.push_back(beat);
    last_accept = cycle_count + 1;
    last_user   = user;
    total_accepted++;
    @(negedge aclk);
    s_axis_tvalid = 1'b0;
  endtask

  // consumer side and output compare
  always @(negedge aclk) begin
    expected_t   want;
    logic [31:0] r;
    if (random_ready) begin
      r             = $urandom();
      m_axis_tready = r[0];
    end else begin
      m_axis_tready = 1'b1;
    end
    if (s_axis_tready === 1'b0 && u_dut.u_slice.count != 2'd2) begin
      error_count++;
      $display("error %s: s_axis_tready low while the slice is not full", test_name);
    end
    if (m_axis_tvalid === 1'b1 && m_axis_tready) begin
      if (expected_q.size() == 0) begin
        error_count++;
        $display("error %s: output beat with no input beat left to match it", test_name);
      end else begin
        want = expected_q.pop_front();
        check_count++;
        if (m_axis_tdata !== want.data) begin
          error_count++;
          $display("error %s: tdata expected %h actual %h", test_name, want.data, m_axis_tdata);
        end
        if (m_axis_tkeep !== want.keep) begin
          error_count++;
          $display("error %s: tkeep expected %h actual %h", test_name, want.keep, m_axis_tkeep);
        end
        if (m_axis_tlast !== want.last) begin
          error_count++;
          $display("error %s: tlast expected %b actual %b", test_name, want.last, m_axis_tlast);
        end
        if (check_latency) begin
          check_value("latency", 3, cycle_count + 1 - want.accept_cycle);
        end
      end
    end
  end

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = error_count;
  endtask

  task automatic end_test();
    while (expected_q.size() != 0) begin
      @(negedge aclk);
    end
    repeat (4) @(negedge aclk);  // room for a stray extra beat
    tests_run++;
    $display("test %s finished with %0d errors", test_name, error_count - test_errors);
  endtask

  task automatic bypass_beats();
    logic [31:0] r;
    begin_test("bypass");
    for (int i = 0; i < 8; i++) begin
      r = $urandom();
      send_beat(random_beat(1'b0), make_user(1'b1, r[0], r[1]));
    end
    end_test();
  endtask

  task automatic vertical_pooling();
    logic [31:0] r;
    begin_test("vertical_w1");
    for (int i = 0; i < 8; i++) begin
      r = $urandom();
      send_beat(random_beat(r[2]), make_user(1'b0, 1'b0, r[1]));
    end
    end_test();
  endtask

  task automatic window_of_three();
    logic [31:0] r;
    begin_test("window3");
    send_beat(edge_beat(), make_user(1'b0, 1'b1, 1'b0));
    send_beat(random_beat(1'b1), make_user(1'b0, 1'b1, 1'b0));
    for (int i = 0; i < 6; i++) begin
      r = $urandom();
      send_beat(random_beat(r[2]), make_user(1'b0, 1'b1, r[1]));
    end
    end_test();
  endtask

  task automatic latency_throughput();
    logic [31:0] r;
    begin_test("latency");
    check_latency = 1'b1;
    for (int i = 0; i < 16; i++) begin
      r = $urandom();
      send_beat(random_beat(r[2]), make_user(r[0], r[1], (i % 4) == 3));
      if (i == 0) begin
        first_accept = last_accept;
      end
    end
    check_value("input accept span", 15, last_accept - first_accept);
    end_test();
    check_latency = 1'b0;
  endtask

  task automatic back_pressure();
    logic [31:0] r;
    begin_test("backpressure");
    random_ready = 1'b1;
    for (int i = 0; i < BP_BEATS; i++) begin
      r = $urandom();
      if (r[4:3] == 2'b00) begin
        @(negedge aclk);  // idle cycle on the input
      end
      send_beat(random_beat(r[5]), make_user(r[0], r[1], r[2]));
    end
    end_test();
    random_ready = 1'b0;
  endtask

  task automatic debug_readback();
    logic [31:0] r;
    begin_test("debug");
    for (int i = 0; i < 6; i++) begin
      r = $urandom();
      send_beat(random_beat(1'b0), make_user(r[0], r[1], r[2]));
    end
    end_test();
    check_value("debug beat count", total_accepted & 32'hffff, debug_config.beat_count);
    check_value("debug is_not_max", last_user.is_not_max, debug_config.is_not_max);
    check_value("debug kernel_h_1", last_user.kernel_h_1, debug_config.kernel_h_1);
  endtask

  initial begin
    void'($urandom(32'hf89));
    reset         = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tuser  = '0;
    last_user     = '0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
    check_value("s_axis_tready after reset", 1, s_axis_tready);
    check_value("m_axis_tvalid after reset", 0, m_axis_tvalid);
    check_value("engine m_valid after reset", 0, u_dut.u_engine.m_valid);
    check_value("debug count after reset", 0, debug_config.beat_count);
    bypass_beats();
    vertical_pooling();
    window_of_three();
    latency_throughput();
    back_pressure();
    debug_readback();
    if (u_dut.u_chk.assert_failures != 0) begin
      error_count += u_dut.u_chk.assert_failures;
      $display("output checker reported %0d assertion failures", u_dut.u_chk.assert_failures);
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+include
hdl/pool_user_pkg.sv
hdl/pool_debug_pkg.sv
hdl/maxpool_engine.sv
hdl/axis_reg_slice_maxpool.sv
hdl/axis_maxpool_engine.sv
bench/axis_maxpool_chk.sv
bench/axis_maxpool_tb.sv

// File: hdl/axis_maxpool_engine.sv
`timescale 1ns/10ps
`include "pool_defaults.svh"

module axis_maxpool_engine
  import pool_user_pkg::*;
  import pool_debug_pkg::*;
#(
  parameter int UNITS        = `UNITS,
  parameter int GROUPS       = `GROUPS,
  parameter int WORD_WIDTH   = `WORD_WIDTH,
  parameter int KERNEL_H_MAX = `KERNEL_H_MAX
) (
  input  logic                                                   aclk,
  input  logic                                                   reset,
  output pool_debug_t                                            debug_config,
  input  logic                                                   s_axis_tvalid,
  output logic                                                   s_axis_tready,
  input  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0]                   s_axis_tdata,
  input  pool_user_t                                             s_axis_tuser,
  output logic                                                   m_axis_tvalid,
  input  logic                                                   m_axis_tready,
  output logic [2*GROUPS*(UNITS+KERNEL_H_MAX-1)*WORD_WIDTH-1:0]  m_axis_tdata,
  output logic [2*GROUPS*(UNITS+KERNEL_H_MAX-1)-1:0]             m_axis_tkeep,
  output logic                                                   m_axis_tlast
);

  localparam int UNITS_EDGES = UNITS + KERNEL_H_MAX - 1;
  localparam int PAD         = KERNEL_H_MAX / 2;  // zero words per side

  logic                                        engine_valid;
  logic                                        engine_last;
  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0]        engine_data;
  logic [2*GROUPS*UNITS-1:0]                   engine_keep;
  logic                                        slice_ready;
  logic [1:0][GROUPS-1:0][UNITS-1:0][WORD_WIDTH-1:0]       slice_words;
  logic [1:0][GROUPS-1:0][UNITS-1:0]                       slice_keep;
  logic [1:0][GROUPS-1:0][UNITS_EDGES-1:0][WORD_WIDTH-1:0] pad_words;
  logic [1:0][GROUPS-1:0][UNITS_EDGES-1:0]                 pad_keep;

  // the engine stalls whenever the slice cannot take more
  assign s_axis_tready = slice_ready;

  maxpool_engine #(
    .UNITS     (UNITS),
    .GROUPS    (GROUPS),
    .WORD_WIDTH(WORD_WIDTH)
  ) u_engine (
    .clk            (aclk),
    .clken          (slice_ready),
    .reset          (reset),
    .debug_config   (debug_config),
    .s_valid        (s_axis_tvalid),
    .s_data_flat_cgu(s_axis_tdata),
    .s_user         (s_axis_tuser),
    .m_valid        (engine_valid),
    .m_data_flat_cgu(engine_data),
    .m_keep_flat_cgu(engine_keep),
    .m_last         (engine_last)
  );

  axis_reg_slice_maxpool #(
    .UNITS     (UNITS),
    .GROUPS    (GROUPS),
    .WORD_WIDTH(WORD_WIDTH)
  ) u_slice (
    .aclk         (aclk),
    .reset        (reset),
    .s_axis_tvalid(engine_valid),
    .s_axis_tready(slice_ready),
    .s_axis_tdata (engine_data),
    .s_axis_tkeep (engine_keep),
    .s_axis_tlast (engine_last),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .m_axis_tdata (slice_words),
    .m_axis_tkeep (slice_keep),
    .m_axis_tlast (m_axis_tlast)
  );

  // centre each row and group, zero words on both sides
  for (genvar c = 0; c < 2; c++) begin : gen_row
    for (genvar g = 0; g < GROUPS; g++) begin : gen_group
      for (genvar e = 0; e < UNITS_EDGES; e++) begin : gen_word
        if (e < PAD || e >= PAD + UNITS) begin : gen_edge
          assign pad_words[c][g][e] = '0;
          assign pad_keep[c][g][e]  = slice_keep[c][g][0];  // follows unit 0
        end else begin : gen_body
          assign pad_words[c][g][e] = slice_words[c][g][e-PAD];
          assign pad_keep[c][g][e]  = slice_keep[c][g][e-PAD];
        end
      end
    end
  end

  assign m_axis_tdata = pad_words;
  assign m_axis_tkeep = pad_keep;

endmodule

// File: hdl/axis_reg_slice_maxpool.sv
`timescale 1ns/10ps
`include "pool_defaults.svh"

module axis_reg_slice_maxpool #(
  parameter int UNITS      = `UNITS,
  parameter int GROUPS     = `GROUPS,
  parameter int WORD_WIDTH = `WORD_WIDTH
) (
  input  logic                                 aclk,
  input  logic                                 reset,
  input  logic                                 s_axis_tvalid,
  output logic                                 s_axis_tready,
  input  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] s_axis_tdata,
  input  logic [2*GROUPS*UNITS-1:0]            s_axis_tkeep,
  input  logic                                 s_axis_tlast,
  output logic                                 m_axis_tvalid,
  input  logic                                 m_axis_tready,
  output logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] m_axis_tdata,
  output logic [2*GROUPS*UNITS-1:0]            m_axis_tkeep,
  output logic                                 m_axis_tlast
);

  typedef struct packed {
    logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] data;
    logic [2*GROUPS*UNITS-1:0]            keep;
    logic                                 last;
  } beat_t;

  beat_t      in_beat;
  beat_t      main_beat;  // head of queue, drives the outputs
  beat_t      skid_beat;  // second entry, only used when stalled
  logic [1:0] count;      // 0, 1 or 2 entries held
  logic [1:0] count_next;
  logic       push;
  logic       pop;

  assign in_beat = '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast};

  assign push = s_axis_tvalid & s_axis_tready;
  assign pop  = m_axis_tvalid & m_axis_tready;

  always_comb begin
    case ({push, pop})
      2'b10:   count_next = count + 2'd1;
      2'b01:   count_next = count - 2'd1;
      default: count_next = count;   // idle, or one in and one out
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      count         <= 2'd0;
      s_axis_tready <= 1'b1;
    end else begin
      count         <= count_next;
      s_axis_tready <= (count_next != 2'd2);  // room for one more
    end
  end

  always_ff @(posedge aclk) begin
    if (pop) begin
      if (count == 2'd2) begin
        main_beat <= skid_beat;  // no push possible while full
      end else if (push) begin
        main_beat <= in_beat;
      end
    end else if (push) begin
      if (count == 2'd0) begin
        main_beat <= in_beat;
      end else begin
        skid_beat <= in_beat;
      end
    end
  end

  assign m_axis_tvalid = (count != 2'd0);
  assign m_axis_tdata  = main_beat.data;
  assign m_axis_tkeep  = main_beat.keep;
  assign m_axis_tlast  = main_beat.last;

endmodule

// File: hdl/maxpool_engine.sv
`timescale 1ns/10ps
`include "pool_defaults.svh"

module maxpool_engine
  import pool_user_pkg::*;
  import pool_debug_pkg::*;
#(
  parameter int UNITS      = `UNITS,
  parameter int GROUPS     = `GROUPS,
  parameter int WORD_WIDTH = `WORD_WIDTH
) (
  input  logic                                 clk,
  input  logic                                 clken,
  input  logic                                 reset,
  output pool_debug_t                          debug_config,
  input  logic                                 s_valid,
  input  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] s_data_flat_cgu,
  input  pool_user_t                           s_user,
  output logic                                 m_valid,
  output logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] m_data_flat_cgu,
  output logic [2*GROUPS*UNITS-1:0]            m_keep_flat_cgu,
  output logic                                 m_last
);

  // word arrays indexed [c][g][u], same bit layout as the flat buses
  typedef logic [1:0][GROUPS-1:0][UNITS-1:0][WORD_WIDTH-1:0] beat_words_t;
  typedef logic [GROUPS-1:0][UNITS-1:0][WORD_WIDTH-1:0]      row_words_t;
  typedef logic [1:0][GROUPS-1:0][UNITS-1:0]                 beat_keep_t;

  beat_words_t s_words;
  row_words_t  v_max;     // vertical maxima of the incoming beat
  row_words_t  h_max;     // horizontal maxima of stage 1
  beat_words_t s1_words;
  pool_user_t  s1_user;
  logic        s1_valid;
  beat_words_t m_words;
  beat_keep_t  m_keep;
  logic        accept;

  function automatic logic [WORD_WIDTH-1:0] smax(
    input logic [WORD_WIDTH-1:0] a,
    input logic [WORD_WIDTH-1:0] b
  );
    return ($signed(a) > $signed(b)) ? a : b;
  endfunction

  assign s_words = s_data_flat_cgu;
  assign accept  = s_valid & clken;

  for (genvar g = 0; g < GROUPS; g++) begin : gen_vgroup
    for (genvar u = 0; u < UNITS; u++) begin : gen_vunit
      assign v_max[g][u] = smax(s_words[0][g][u], s_words[1][g][u]);
    end
  end

  // stage 1: vertical pooling
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (clken) begin
      s1_valid <= s_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      s1_user     <= s_user;
      s1_words[1] <= s_words[1];  // only read in bypass
      if (s_user.is_not_max) begin
        s1_words[0] <= s_words[0];
      end else begin
        s1_words[0] <= v_max;
      end
    end
  end

  // horizontal window of three, neighbours outside the group fall back to centre
  for (genvar g = 0; g < GROUPS; g++) begin : gen_hgroup
    for (genvar u = 0; u < UNITS; u++) begin : gen_hunit
      logic [WORD_WIDTH-1:0] left;
      logic [WORD_WIDTH-1:0] right;
      logic [WORD_WIDTH-1:0] centre;

      assign centre = s1_words[0][g][u];

      if (u > 0) begin : gen_left
        assign left = s1_words[0][g][u-1];
      end else begin : gen_left_edge
        assign left = centre;
      end

      if (u < UNITS - 1) begin : gen_right
        assign right = s1_words[0][g][u+1];
      end else begin : gen_right_edge
        assign right = centre;
      end

      assign h_max[g][u] = s1_user.kernel_h_1 ? smax(smax(left, centre), right) : centre;
    end
  end

  // stage 2: horizontal pooling, keep pattern and last
  always_ff @(posedge clk) begin
    if (reset) begin
      m_valid <= 1'b0;
    end else if (clken) begin
      m_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      m_last <= s1_user.last;
      if (s1_user.is_not_max) begin
        m_words <= s1_words;
        m_keep  <= '1;
      end else begin
        m_words[0] <= h_max;
        m_words[1] <= '0;        // row 1 unused after pooling
        m_keep[0]  <= '1;
        m_keep[1]  <= '0;
      end
    end
  end

  assign m_data_flat_cgu = m_words;
  assign m_keep_flat_cgu = m_keep;

  // debug snapshot of accepted beats
  always_ff @(posedge clk) begin
    if (reset) begin
      debug_config <= '0;
    end else if (accept) begin
      debug_config.is_not_max <= s_user.is_not_max;
      debug_config.kernel_h_1 <= s_user.kernel_h_1;
      debug_config.beat_count <= debug_config.beat_count + 1'b1;
    end
  end

endmodule

// File: hdl/pool_debug_pkg.sv
package pool_debug_pkg;

  localparam int DEBUG_COUNT_WIDTH = 16;

  // observability word, updated on every accepted input beat
  typedef struct packed {
    logic                         is_not_max;  // mode of last accepted beat
    logic                         kernel_h_1;
    logic [DEBUG_COUNT_WIDTH-1:0] beat_count;  // wraps silently
  } pool_debug_t;

  localparam int DEBUG_CONFIG_WIDTH_MAXPOOL = $bits(pool_debug_t);

endpackage

// File: hdl/pool_user_pkg.sv
package pool_user_pkg;

  // sideband that travels with each input beat on tuser
  typedef struct packed {
    logic is_not_max;  // 1 passes the beat through untouched
    logic kernel_h_1;  // 0 window of 1, 1 window of 3
    logic last;        // end of frame
  } pool_user_t;

  localparam int TUSER_WIDTH_MAXPOOL_IN = $bits(pool_user_t);

endpackage

// File: include/pool_defaults.svh
`ifndef POOL_DEFAULTS_SVH
`define POOL_DEFAULTS_SVH

// default geometry of the pooling block
`define UNITS        4  // words per group
`define GROUPS       2  // groups per row
`define WORD_WIDTH   8  // signed word width
`define KERNEL_H_MAX 3  // odd, sets the zero edge width

`endif
